//--- Makefile
TOOL     = verilator
TOP      = fprint_tb
FILELIST = vlog.f
FLAGS    = --binary --timing --assert -j 0
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- logic/context_if.sv
interface context_if import fprint_pkg::*; #(
	parameter type entry_t = context_t
);

	logic   push;       // write strobe from the engine
	entry_t push_data;  // context being saved
	logic   pop;        // remove top entry, from the controller
	entry_t top_data;   // valid while empty_n is high
	logic   empty_n;    // stack holds at least one entry

	// the lifo itself
	modport stack (
		input  push,
		input  push_data,
		input  pop,
		output top_data,
		output empty_n
	);

	// crc engine saves and restores through here
	modport saver (
		output push,
		output push_data,
		input  top_data
	);

	modport ctrl (
		output pop,
		input  empty_n,
		input  top_data
	);

endinterface

//--- logic/context_stack.sv
module context_stack #(
	parameter int  DEPTH   = 4,
	parameter type entry_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst,
	context_if.stack ctx
);

	localparam int PTR_W = $clog2(DEPTH + 1);              // counts 0..DEPTH
	localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	entry_t             mem [DEPTH];   // saved contexts, no reset needed
	logic [PTR_W-1:0]   ptr;           // number of live entries
	logic [IDX_W-1:0]   top_idx;
	logic               full;
	logic               push_ok;
	logic               pop_ok;

	assign full    = (ptr == PTR_W'(DEPTH));
	assign push_ok = ctx.push & ~full;         // push to a full stack is dropped
	assign pop_ok  = ctx.pop & ctx.empty_n;
	// entry just below the pointer, held at 0 when empty
	assign top_idx = (ptr == '0) ? '0 : IDX_W'(ptr - 1'b1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else begin
			case ({push_ok, pop_ok})
				2'b10:   ptr <= ptr + 1'b1;
				2'b01:   ptr <= ptr - 1'b1;
				default: ptr <= ptr;    // both or neither leaves depth as is
			endcase
		end
	end

	// storage write
	always_ff @(posedge clk) begin
		if (push_ok && pop_ok)
			mem[top_idx] <= ctx.push_data;              // replace top in place
		else if (push_ok)
			mem[IDX_W'(ptr)] <= ctx.push_data;
	end

	assign ctx.top_data = mem[top_idx];
	assign ctx.empty_n  = (ptr != '0);

	// overflow is not recovered, a lost context shows up here
	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		ctx.push |-> !full);

	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		ctx.pop |-> ctx.empty_n);

endmodule

//--- logic/crc_engine.sv
module crc_engine import fprint_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       fprint_enable,
	input  logic       data_valid,
	input  logic [7:0] data_in,
	input  logic       task_load,
	input  task_t      task_in,
	input  logic       pause_store,
	input  logic       pause_reset,
	input  logic       unpause_load,
	output crc_t       crc_out,
	output task_t      task_out,
	context_if.saver   ctx
);

	crc_t  crc_q;       // running fingerprint
	task_t task_q;      // owner of the running fingerprint
	logic  pulse_busy;
	logic  byte_take;
	logic  task_take;

	// any controller pulse freezes the datapath for that cycle
	assign pulse_busy = pause_store | pause_reset | unpause_load;
	assign byte_take  = data_valid & fprint_enable & ~pulse_busy;
	assign task_take  = task_load & ~pulse_busy;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			crc_q  <= CRC_INIT;
			task_q <= '0;
		end else if (pause_reset) begin
			crc_q <= CRC_INIT;                     // free the engine for the next task
		end else if (unpause_load) begin
			crc_q  <= ctx.top_data.crc;            // restore saved context
			task_q <= ctx.top_data.task_id;
		end else if (task_take) begin
			crc_q  <= CRC_INIT;                    // new task starts a fresh fingerprint
			task_q <= task_in;
		end else if (byte_take) begin
			crc_q <= crc_next_byte(crc_q, data_in);
		end
	end

	// context push, written by the stack on this same edge
	assign ctx.push      = pause_store;
	assign ctx.push_data = {task_q, crc_q};

	assign crc_out  = crc_q;
	assign task_out = task_q;

endmodule

//--- logic/fprint_pkg.sv
package fprint_pkg;

	// fingerprint geometry
	localparam int CRC_WIDTH  = 16;
	localparam int NUM_TASKS  = 4;                 // also the pause mask width
	localparam int TASK_WIDTH = 2;

	typedef logic [CRC_WIDTH-1:0]  crc_t;
	typedef logic [TASK_WIDTH-1:0] task_t;

	localparam crc_t CRC_POLY = 16'h1021;          // ccitt generator
	localparam crc_t CRC_INIT = 16'hFFFF;          // reset and clear value

	// saved context, task id in the upper bits
	typedef struct packed {
		task_t task_id;
		crc_t  crc;
	} context_t;

	// one byte of crc, msb first, bitwise shift register form
	function automatic crc_t crc_next_byte(input crc_t crc, input logic [7:0] data);
		crc_t c;
		c = crc ^ (crc_t'(data) << (CRC_WIDTH - 8));   // byte lines up with the top bits
		for (int i = 0; i < 8; i++) begin
			if (c[CRC_WIDTH-1])
				c = (c << 1) ^ CRC_POLY;
			else
				c = c << 1;
		end
		return c;
	endfunction

endpackage

//--- logic/fprint_top.sv
module fprint_top import fprint_pkg::*; #(
	parameter int STACK_DEPTH = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 fprint_enable,
	input  logic                 data_valid,
	input  logic [7:0]           data_in,
	input  logic                 task_load,
	input  task_t                task_in,
	input  logic                 pause_reg,
	input  logic                 unpause_reg,
	input  logic [NUM_TASKS-1:0] pause_task_reg,
	output logic                 waitrequest,
	output crc_t                 crc_out,
	output task_t                task_out,
	output logic                 stack_empty_n
);

	logic pause_store;
	logic pause_reset;
	logic unpause_load;
	logic unpause_setfsm;
	logic engine_valid;

	context_if #(.entry_t(context_t)) ctx_bus ();

	// bytes during the pop and release cycles are dropped as well
	assign engine_valid = data_valid & ~waitrequest & ~unpause_setfsm;

	pause_ctrl u_ctrl (
		.clk            (clk),
		.rst            (rst),
		.pause_reg      (pause_reg),
		.unpause_reg    (unpause_reg),
		.fprint_enable  (fprint_enable),
		.pause_task_reg (pause_task_reg),
		.pause_store    (pause_store),
		.pause_reset    (pause_reset),
		.unpause_load   (unpause_load),
		.unpause_setfsm (unpause_setfsm),
		.waitrequest    (waitrequest),
		.ctx            (ctx_bus.ctrl)
	);

	crc_engine u_engine (
		.clk           (clk),
		.rst           (rst),
		.fprint_enable (fprint_enable),
		.data_valid    (engine_valid),
		.data_in       (data_in),
		.task_load     (task_load),
		.task_in       (task_in),
		.pause_store   (pause_store),
		.pause_reset   (pause_reset),
		.unpause_load  (unpause_load),
		.crc_out       (crc_out),
		.task_out      (task_out),
		.ctx           (ctx_bus.saver)
	);

	context_stack #(
		.DEPTH   (STACK_DEPTH),
		.entry_t (context_t)
	) u_stack (
		.clk (clk),
		.rst (rst),
		.ctx (ctx_bus.stack)
	);

	assign stack_empty_n = ctx_bus.empty_n;   // status for the host side

endmodule

//--- logic/pause_ctrl.sv
module pause_ctrl import fprint_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 pause_reg,
	input  logic                 unpause_reg,
	input  logic                 fprint_enable,
	input  logic [NUM_TASKS-1:0] pause_task_reg,
	output logic                 pause_store,
	output logic                 pause_reset,
	output logic                 unpause_load,
	output logic                 unpause_setfsm,
	output logic                 waitrequest,
	context_if.ctrl              ctx
);

	typedef enum logic [1:0] {
		P_IDLE,
		P_STORE,
		P_RESET,
		P_RELEASE
	} pause_state_t;

	typedef enum logic [1:0] {
		U_IDLE,
		U_LOAD,
		U_SETFSM,
		U_RELEASE
	} unpause_state_t;

	pause_state_t   pause_state;
	unpause_state_t unpause_state;
	logic           unpause_go;

	// top task still masked means its context must stay on the stack
	assign unpause_go = unpause_reg & ctx.empty_n & ~pause_task_reg[ctx.top_data.task_id];

	// pause loop, strobes ignored unless idle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pause_state <= P_IDLE;
		end else begin
			case (pause_state)
				P_IDLE:    pause_state <= (pause_reg & fprint_enable) ? P_STORE : P_IDLE;
				P_STORE:   pause_state <= P_RESET;   // push happens here
				P_RESET:   pause_state <= P_RELEASE; // accumulator cleared
				P_RELEASE: pause_state <= P_IDLE;
				default:   pause_state <= P_IDLE;
			endcase
		end
	end

	// unpause loop, load first, then pop
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			unpause_state <= U_IDLE;
		end else begin
			case (unpause_state)
				U_IDLE:    unpause_state <= unpause_go ? U_LOAD : U_IDLE;
				U_LOAD:    unpause_state <= U_SETFSM;
				U_SETFSM:  unpause_state <= U_RELEASE;
				U_RELEASE: unpause_state <= U_IDLE;
				default:   unpause_state <= U_IDLE;
			endcase
		end
	end

	assign pause_store    = (pause_state == P_STORE);
	assign pause_reset    = (pause_state == P_RESET);
	assign unpause_load   = (unpause_state == U_LOAD);
	assign unpause_setfsm = (unpause_state == U_SETFSM);
	assign waitrequest    = (pause_state == P_RELEASE) | (unpause_state == U_RELEASE);
	assign ctx.pop        = unpause_setfsm;   // pop once the engine has the context

	// a save and a restore in the same cycle would fight over the engine registers
	a_no_store_load: assert property (@(posedge clk) disable iff (rst)
		!(pause_store && unpause_load));

	// the stack was checked non-empty two cycles before, nothing may drain it since
	a_pop_nonempty: assert property (@(posedge clk) disable iff (rst)
		unpause_setfsm |-> ctx.empty_n);

endmodule

//--- testbench/fprint_tb.sv
module fprint_tb import fprint_pkg::*; ();

	logic                 clk;
	logic                 rst;
	logic                 fprint_enable;
	logic                 data_valid;
	logic [7:0]           data_in;
	logic                 task_load;
	task_t                task_in;
	logic                 pause_reg;
	logic                 unpause_reg;
	logic [NUM_TASKS-1:0] pause_task_reg;
	logic                 waitrequest;
	crc_t                 crc_out;
	task_t                task_out;
	logic                 stack_empty_n;

	crc_t     exp_crc;      // model fingerprint of the running task
	task_t    exp_task;
	int       exp_depth;    // model stack depth
	context_t saved [$];    // model stack with the top at the back
	logic     steady;       // no sequence running so outputs must follow the model
	logic     wr_expect;    // this strobe has to start a sequence
	string    test_name;
	integer   seed;

	fprint_top #(.STACK_DEPTH(4)) UUT (
		.clk            (clk),
		.rst            (rst),
		.fprint_enable  (fprint_enable),
		.data_valid     (data_valid),
		.data_in        (data_in),
		.task_load      (task_load),
		.task_in        (task_in),
		.pause_reg      (pause_reg),
		.unpause_reg    (unpause_reg),
		.pause_task_reg (pause_task_reg),
		.waitrequest    (waitrequest),
		.crc_out        (crc_out),
		.task_out       (task_out),
		.stack_empty_n  (stack_empty_n)
	);

	always #2 clk = ~clk;

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	// reference crc as a bit serial lfsr over poly 0x1021 msb first
	function automatic crc_t model_crc(input crc_t crc, input logic [7:0] b);
		crc_t c;
		logic fb;
		c = crc;
		for (int i = 7; i >= 0; i--) begin
			fb = c[15] ^ b[i];
			c  = {c[14:0], 1'b0};
			if (fb)
				c = c ^ 16'h1021;
		end
		return c;
	endfunction

	a_crc: assert property (@(posedge clk) disable iff (rst) steady |-> crc_out == exp_crc)
		else fail_stop($sformatf("error %s: crc_out expected %h actual %h",
			test_name, $sampled(exp_crc), $sampled(crc_out)));

	a_task: assert property (@(posedge clk) disable iff (rst) steady |-> task_out == exp_task)
		else fail_stop($sformatf("error %s: task_out expected %0d actual %0d",
			test_name, $sampled(exp_task), $sampled(task_out)));

	a_empty: assert property (@(posedge clk) disable iff (rst)
		steady |-> stack_empty_n == (exp_depth != 0))
		else fail_stop($sformatf("error %s: stack_empty_n expected %0d actual %0d",
			test_name, $sampled(exp_depth) != 0, $sampled(stack_empty_n)));

	a_idle: assert property (@(posedge clk) disable iff (rst) steady |-> !waitrequest)
		else fail_stop($sformatf("error %s: waitrequest expected 0 actual 1", test_name));

	// store or load then reset or pop then one release cycle
	a_pulse: assert property (@(posedge clk) disable iff (rst)
		wr_expect |-> ##1 !waitrequest ##1 !waitrequest ##1 waitrequest ##1 !waitrequest)
		else fail_stop($sformatf(
			"error %s: waitrequest was not one pulse three cycles after the strobe",
			test_name));

	task automatic load_task(input task_t t);
		task_load = 1'b1;
		task_in   = t;
		@(negedge clk);
		task_load = 1'b0;
		exp_task  = t;
		exp_crc   = 16'hFFFF;    // new task starts fresh
	endtask

	task automatic send_byte(input logic [7:0] b);
		data_valid = 1'b1;
		data_in    = b;
		@(negedge clk);
		data_valid = 1'b0;
		exp_crc    = model_crc(exp_crc, b);   // absorbed at the edge just passed
	endtask

	task automatic send_random(input int n);
		logic [7:0] b;
		repeat (n) begin
			b = 8'($random(seed));
			send_byte(b);
		end
	endtask

	task automatic wait_release();
		int n;
		n = 0;
		while (waitrequest !== 1'b1 && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (waitrequest !== 1'b1) begin
			fail_stop($sformatf("%s: waitrequest never went high", test_name));
		end else begin
			n = 0;
			while (waitrequest !== 1'b0 && n < 8) begin
				@(negedge clk);
				n++;
			end
			if (waitrequest !== 1'b0)
				fail_stop($sformatf("%s: waitrequest stuck high", test_name));
		end
	endtask

	// one cycle strobe where run says whether the fsm must accept it
	task automatic strobe(input logic is_pause, input logic run);
		steady    = ~run;
		wr_expect = run;
		if (is_pause)
			pause_reg = 1'b1;
		else
			unpause_reg = 1'b1;
		@(negedge clk);
		pause_reg   = 1'b0;
		unpause_reg = 1'b0;
		wr_expect   = 1'b0;
		if (run)
			wait_release();
		else
			repeat (4) @(negedge clk);   // a full sequence length of nothing
	endtask

	task automatic pause_and_save();
		strobe(1'b1, 1'b1);
		saved.push_back({exp_task, exp_crc});
		exp_depth = saved.size();
		exp_crc   = 16'hFFFF;    // engine cleared with the task id kept
		steady    = 1'b1;
	endtask

	task automatic unpause_and_restore();
		context_t c;
		strobe(1'b0, 1'b1);
		c         = saved.pop_back();
		exp_depth = saved.size();
		exp_task  = c.task_id;
		exp_crc   = c.crc;
		steady    = 1'b1;
	endtask

	initial begin
		seed           = 97;
		clk            = 1'b0;
		rst            = 1'b1;
		fprint_enable  = 1'b0;
		data_valid     = 1'b0;
		data_in        = '0;
		task_load      = 1'b0;
		task_in        = '0;
		pause_reg      = 1'b0;
		unpause_reg    = 1'b0;
		pause_task_reg = '0;
		steady         = 1'b0;
		wr_expect      = 1'b0;
		exp_crc        = 16'hFFFF;
		exp_task       = '0;
		exp_depth      = 0;
		test_name      = "after reset";
		repeat (4) @(negedge clk);
		rst    = 1'b0;
		steady = 1'b1;    // reset values checked from here on
		repeat (2) @(negedge clk);

		test_name     = "plain stream";
		fprint_enable = 1'b1;
		load_task(2'd1);
		for (int i = 1; i <= 9; i++)
			send_byte(8'h30 + 8'(i));   // ascii 123456789
		exp_crc = 16'h29B1;             // published check value for this crc
		send_random(24);

		test_name = "pause";
		pause_and_save();
		test_name     = "pause disabled";
		fprint_enable = 1'b0;
		strobe(1'b1, 1'b0);
		fprint_enable = 1'b1;

		test_name = "unpause";
		load_task(2'd2);
		send_random(12);
		unpause_and_restore();
		send_random(12);    // task 1 stream carries on as if never paused

		test_name = "unpause empty";
		strobe(1'b0, 1'b0);

		test_name = "unpause masked";
		pause_and_save();
		load_task(2'd3);
		send_random(8);
		pause_task_reg = 4'b0010;    // task 1 is on top and still held
		strobe(1'b0, 1'b0);
		pause_task_reg = '0;

		test_name = "nested";
		pause_and_save();          // task 3 over task 1
		load_task(2'd0);
		send_random(8);
		unpause_and_restore();     // task 3 back first
		send_random(8);
		unpause_and_restore();
		send_random(8);

		repeat (2) @(negedge clk);
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- vlog.f
logic/fprint_pkg.sv
logic/context_if.sv
logic/pause_ctrl.sv
logic/context_stack.sv
logic/crc_engine.sv
logic/fprint_top.sv
testbench/fprint_tb.sv
